// File: common/mem_cfg_pkg.sv
/*
 * Address map, bus widths and opcode encoding of the memory unit.
 * Referenced by scoped name from the RTL and the testbench.
 */
package mem_cfg_pkg;

    // Bus widths
    parameter int unsigned ADDR_WIDTH   = 32;
    parameter int unsigned DATA_WIDTH   = 32;
    parameter int unsigned BYTEEN_WIDTH = DATA_WIDTH / 8;
    parameter int unsigned TAG_WIDTH    = 8;

    // Local memory window, aligned to its own size
    parameter logic [ADDR_WIDTH-1:0] LMEM_BASE_ADDR = 32'h0001_0000;
    parameter int unsigned           LMEM_LOG_SIZE  = 10;

    // Word offset bits below the window index
    parameter int unsigned WORD_OFFSET_BITS = $clog2(BYTEEN_WIDTH);

    // Memory opcode carried with every request
    typedef enum logic [0:0] {
        MEM_OP_READ  = 1'b0,
        MEM_OP_WRITE = 1'b1
    } mem_op_e;

endpackage

// File: common/mem_types_pkg.sv
/*
 * Request and response payloads of the LSU, local memory and cache ports.
 * Every valid/ready port of the design carries one of these structs.
 */
package mem_types_pkg;

    // One word access from the LSU, 77 bits wide
    typedef struct packed {
        // Read or write
        mem_cfg_pkg::mem_op_e                   op;

        // Byte address of the word
        logic [mem_cfg_pkg::ADDR_WIDTH-1:0]     addr;

        // Bytes written, ignored on reads
        logic [mem_cfg_pkg::BYTEEN_WIDTH-1:0]   byteen;

        // Write data, ignored on reads
        logic [mem_cfg_pkg::DATA_WIDTH-1:0]     data;

        // Returned unchanged with the read response
        logic [mem_cfg_pkg::TAG_WIDTH-1:0]      tag;
    } mem_req_t;

    // Read response, 40 bits wide
    typedef struct packed {
        // Word read from local memory or the cache
        logic [mem_cfg_pkg::DATA_WIDTH-1:0]     data;

        // Tag of the read this word belongs to
        logic [mem_cfg_pkg::TAG_WIDTH-1:0]      tag;
    } mem_rsp_t;

endpackage

// File: dv/mem_unit_checker.sv
/*
 * Scoreboard of the memory unit testbench. Holds the expected data of each
 * outstanding read by tag and the order of requests due on the cache port.
 */
module mem_unit_checker (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               lsu_req_valid,
    input  mem_types_pkg::mem_req_t            lsu_req,
    input  logic                               lsu_req_ready,
    input  logic [mem_cfg_pkg::DATA_WIDTH-1:0] exp_data,
    input  logic                               dc_req_valid,
    input  mem_types_pkg::mem_req_t            dc_req,
    input  logic                               dc_req_ready,
    input  logic                               lsu_rsp_valid,
    input  mem_types_pkg::mem_rsp_t            lsu_rsp,
    input  logic                               lsu_rsp_ready,
    output int                                 data_errors,
    output int                                 order_errors,
    output int                                 tag_errors,
    output int                                 outstanding,
    output int                                 gq_pending,
    output int                                 rsp_count
);
    localparam int unsigned TAGS    = 1 << mem_cfg_pkg::TAG_WIDTH;
    localparam logic [31:0] WIN_END =
        mem_cfg_pkg::LMEM_BASE_ADDR + (32'd1 << mem_cfg_pkg::LMEM_LOG_SIZE);

    logic [mem_cfg_pkg::DATA_WIDTH-1:0] exp_by_tag [TAGS];
    logic                               pending [TAGS];
    mem_types_pkg::mem_req_t            gq_expect [$];

    always @(posedge clk) begin : score
        mem_types_pkg::mem_req_t head;
        if (!rst_n) begin
            for (int t = 0; t < TAGS; t++) begin
                pending[t] = 1'b0;
            end
            gq_expect.delete();
            data_errors  = 0;
            order_errors = 0;
            tag_errors   = 0;
            outstanding  = 0;
            gq_pending   = 0;
            rsp_count    = 0;
        end else begin
            if (lsu_req_valid && lsu_req_ready) begin
                // Anything outside the window must reach the cache unchanged
                if (lsu_req.addr < mem_cfg_pkg::LMEM_BASE_ADDR || lsu_req.addr >= WIN_END) begin
                    gq_expect.push_back(lsu_req);
                end
                if (lsu_req.op == mem_cfg_pkg::MEM_OP_READ) begin
                    if (pending[lsu_req.tag]) begin
                        $display("Read with tag %02h sent at %0t while that tag is still outstanding",
                                 lsu_req.tag, $time);
                        tag_errors++;
                    end
                    pending[lsu_req.tag]    = 1'b1;
                    exp_by_tag[lsu_req.tag] = exp_data;
                    outstanding++;
                end
            end
            if (dc_req_valid && dc_req_ready) begin
                if (gq_expect.size() == 0) begin
                    $display("Request on the cache port at %0t was never sent on the global path",
                             $time);
                    order_errors++;
                end else begin
                    head = gq_expect.pop_front();
                    if (dc_req !== head) begin
                        $display("FAILED %0t: cache request %h, expected %h", $time, dc_req, head);
                        order_errors++;
                    end
                end
            end
            if (lsu_rsp_valid && lsu_rsp_ready) begin
                rsp_count++;
                if (!pending[lsu_rsp.tag]) begin
                    $display("Response with tag %02h at %0t matches no outstanding read",
                             lsu_rsp.tag, $time);
                    tag_errors++;
                end else begin
                    pending[lsu_rsp.tag] = 1'b0;
                    outstanding--;
                    if (lsu_rsp.data !== exp_by_tag[lsu_rsp.tag]) begin
                        $display("FAILED %0t: tag %02h returned %08h, expected %08h", $time,
                                 lsu_rsp.tag, lsu_rsp.data, exp_by_tag[lsu_rsp.tag]);
                        data_errors++;
                    end
                end
            end
            gq_pending = gq_expect.size();
        end
    end

endmodule

// File: dv/mem_unit_tb.sv
/*
 * Testbench of the memory unit. Drives the LSU port from the vector file and
 * models the data cache; mem_unit_checker compares all responses.
 */
module mem_unit_tb;
    localparam int unsigned MAX_VECS   = 64;
    localparam int unsigned VEC_FIELDS = 6;
    localparam int unsigned TIMEOUT    = 200;
    localparam logic [31:0] FILL_KEY   = 32'hc0de_0000;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    lsu_req_valid;
    mem_types_pkg::mem_req_t lsu_req;
    logic                    lsu_req_ready;
    logic                    lsu_rsp_valid;
    mem_types_pkg::mem_rsp_t lsu_rsp;
    logic                    lsu_rsp_ready = 1'b0;
    logic                    dc_req_valid;
    mem_types_pkg::mem_req_t dc_req;
    logic                    dc_req_ready = 1'b0;
    logic                    dc_rsp_valid = 1'b0;
    mem_types_pkg::mem_rsp_t dc_rsp = '0;
    logic                    dc_rsp_ready;

    logic [31:0]             exp_data;
    logic                    req_accepted = 1'b0;
    logic                    dc_rsp_taken = 1'b0;
    logic [31:0]             lfsr = 32'hce7d;
    int unsigned             rsp_gap = 0;
    logic [31:0]             vec_mem [MAX_VECS*VEC_FIELDS];
    logic [31:0]             cache_words [logic [29:0]];
    mem_types_pkg::mem_rsp_t cache_rsp_q [$];

    int data_errors;
    int order_errors;
    int tag_errors;
    int outstanding;
    int gq_pending;
    int rsp_count;

    mem_unit #(
        .GQ_DEPTH   (4),
        .LMEM_WORDS (256)
    ) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .lsu_req_valid (lsu_req_valid),
        .lsu_req       (lsu_req),
        .lsu_req_ready (lsu_req_ready),
        .lsu_rsp_valid (lsu_rsp_valid),
        .lsu_rsp       (lsu_rsp),
        .lsu_rsp_ready (lsu_rsp_ready),
        .dc_req_valid  (dc_req_valid),
        .dc_req        (dc_req),
        .dc_req_ready  (dc_req_ready),
        .dc_rsp_valid  (dc_rsp_valid),
        .dc_rsp        (dc_rsp),
        .dc_rsp_ready  (dc_rsp_ready)
    );

    mem_unit_checker i_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .lsu_req_valid (lsu_req_valid),
        .lsu_req       (lsu_req),
        .lsu_req_ready (lsu_req_ready),
        .exp_data      (exp_data),
        .dc_req_valid  (dc_req_valid),
        .dc_req        (dc_req),
        .dc_req_ready  (dc_req_ready),
        .lsu_rsp_valid (lsu_rsp_valid),
        .lsu_rsp       (lsu_rsp),
        .lsu_rsp_ready (lsu_rsp_ready),
        .data_errors   (data_errors),
        .order_errors  (order_errors),
        .tag_errors    (tag_errors),
        .outstanding   (outstanding),
        .gq_pending    (gq_pending),
        .rsp_count     (rsp_count)
    );

    always #10 clk = ~clk;

    // Taps at 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    // Words never written hold a pattern of their own address
    function automatic logic [31:0] cache_word(input logic [31:0] addr);
        if (cache_words.exists(addr[31:2])) begin
            return cache_words[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ FILL_KEY;
    endfunction

    always @(posedge clk) begin
        req_accepted <= lsu_req_valid && lsu_req_ready;
        dc_rsp_taken <= dc_rsp_valid && dc_rsp_ready;
    end

    always @(posedge clk) begin : cache_accept
        logic [31:0]             word;
        mem_types_pkg::mem_rsp_t rsp;
        if (dc_req_valid && dc_req_ready) begin
            word = cache_word(dc_req.addr);
            if (dc_req.op == mem_cfg_pkg::MEM_OP_WRITE) begin
                for (int b = 0; b < mem_cfg_pkg::BYTEEN_WIDTH; b++) begin
                    if (dc_req.byteen[b]) begin
                        word[b*8 +: 8] = dc_req.data[b*8 +: 8];
                    end
                end
                cache_words[dc_req.addr[31:2]] = word;
            end else begin
                rsp.data = word;
                rsp.tag  = dc_req.tag;
                cache_rsp_q.push_back(rsp);
            end
        end
    end

    // Random stalls on both ready inputs, cache reads answered in order after 1 to 4 cycles
    always @(negedge clk) begin : cache_drive
        logic b0;
        logic b1;
        take_bit(b0);
        dc_req_ready = b0;
        take_bit(b0);
        take_bit(b1);
        lsu_rsp_ready = b0 | b1;
        if (dc_rsp_taken) begin
            dc_rsp_valid = 1'b0;
        end
        if (!dc_rsp_valid && cache_rsp_q.size() != 0) begin
            if (rsp_gap == 0) begin
                take_bit(b0);
                take_bit(b1);
                rsp_gap = {b1, b0} + 1;
            end
            rsp_gap = rsp_gap - 1;
            if (rsp_gap == 0) begin
                dc_rsp       = cache_rsp_q.pop_front();
                dc_rsp_valid = 1'b1;
            end
        end
    end

    initial begin : driver
        int unsigned             n_vecs;
        int unsigned             n_reads;
        int unsigned             base;
        int unsigned             cycles;
        int                      count_errors;
        int                      missing;
        int                      timeouts;
        logic                    accepted;
        mem_types_pkg::mem_req_t req;
        rst_n         = 1'b0;
        lsu_req_valid = 1'b0;
        lsu_req       = '0;
        exp_data      = '0;
        n_reads       = 0;
        count_errors  = 0;
        missing       = 0;
        timeouts      = 0;
        for (int i = 0; i < MAX_VECS * VEC_FIELDS; i++) begin
            vec_mem[i] = '1;
        end
        $readmemh("dv/mem_unit_vectors.txt", vec_mem);
        n_vecs = 0;
        while (n_vecs < MAX_VECS && vec_mem[n_vecs*VEC_FIELDS] < 2) begin
            n_vecs++;
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int unsigned v = 0; v < n_vecs && timeouts == 0; v++) begin
            base       = v * VEC_FIELDS;
            req.op     = mem_cfg_pkg::mem_op_e'(vec_mem[base][0]);
            req.addr   = vec_mem[base+1];
            req.byteen = vec_mem[base+2][3:0];
            req.data   = vec_mem[base+3];
            req.tag    = vec_mem[base+4][7:0];
            if (req.op == mem_cfg_pkg::MEM_OP_READ) begin
                n_reads++;
            end
            lsu_req       = req;
            exp_data      = vec_mem[base+5];
            lsu_req_valid = 1'b1;
            accepted      = 1'b0;
            cycles        = 0;
            while (!accepted && cycles < TIMEOUT) begin
                @(negedge clk);
                accepted = req_accepted;
                cycles++;
            end
            lsu_req_valid = 1'b0;
            if (!accepted) begin
                $display("Request %0d with tag %02h was not accepted within %0d cycles",
                         v, req.tag, TIMEOUT);
                timeouts++;
            end
        end

        cycles = 0;
        while (timeouts == 0 && (outstanding != 0 || gq_pending != 0)) begin
            if (cycles == TIMEOUT) begin
                $display("%0d reads got no response and %0d requests never reached the cache",
                         outstanding, gq_pending);
                missing = outstanding + gq_pending;
                timeouts++;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        // Idle time so that a stray extra response would still be seen
        repeat (10) @(negedge clk);
        if (timeouts == 0 && rsp_count != int'(n_reads)) begin
            $display("Got %0d responses for %0d reads", rsp_count, n_reads);
            count_errors++;
        end

        $display("Errors: data %0d, cache order %0d, tag %0d, count %0d, missing %0d, timeout %0d",
                 data_errors, order_errors, tag_errors, count_errors, missing, timeouts);
        if (data_errors + order_errors + tag_errors + count_errors + missing + timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/mem_unit_vectors.txt
// op (0 read, 1 write)  address  byteen  write data  tag  expected read data
// Local window 00010000-000103ff, other cache words read as address ^ c0de0000
1 00010000 f 11223344 01 00000000
0 00010000 0 00000000 02 11223344
1 00010004 f aabbccdd 03 00000000
1 00010004 5 00ee00ff 04 00000000
1 00010004 8 99000000 05 00000000
0 00010004 0 00000000 06 99eeccff
1 000103fc f deadbeef 07 00000000
1 000103fc 2 0000a500 08 00000000
0 000103fc 0 00000000 09 deada5ef
0 00002000 0 00000000 0a c0de2000
1 00002004 f 01020304 0b 00000000
0 00002004 0 00000000 0c 01020304
1 00002004 3 0000bbaa 0d 00000000
0 00002004 0 00000000 0e 0102bbaa
0 00010400 0 00000000 0f c0df0400
0 0000fffc 0 00000000 10 c0defffc
0 00003000 0 00000000 11 c0de3000
0 00010000 0 00000000 12 11223344
0 00003004 0 00000000 13 c0de3004
0 00010004 0 00000000 14 99eeccff
0 00003008 0 00000000 15 c0de3008
0 000103fc 0 00000000 16 deada5ef
1 00004000 f cafef00d 17 00000000
1 00004004 f 0badc0de 18 00000000
1 00004008 1 00000077 19 00000000
0 00004000 0 00000000 1a cafef00d
0 00004004 0 00000000 1b 0badc0de
0 00004008 0 00000000 1c c0de4077
0 0000400c 0 00000000 1d c0de400c
1 00010008 f 5555aaaa 1e 00000000
0 00010008 0 00000000 1f 5555aaaa
0 00003000 0 00000000 20 c0de3000

// File: filelist.f
common/mem_cfg_pkg.sv
common/mem_types_pkg.sv
verilog/lmem_switch.sv
verilog/req_fifo.sv
local_mem/local_mem.sv
verilog/mem_unit.sv
dv/mem_unit_checker.sv
dv/mem_unit_tb.sv

// File: local_mem/local_mem.sv
/*
 * Single-ported local word memory with byte-enable writes.
 * Read data waits in one response register that the consumer can stall.
 */
module local_mem #(
    parameter int unsigned WORDS = 256
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    req_valid,
    input  mem_types_pkg::mem_req_t req,
    output logic                    req_ready,

    output logic                    rsp_valid,
    output mem_types_pkg::mem_rsp_t rsp,
    input  logic                    rsp_ready
);
    localparam int unsigned LOG_SIZE = mem_cfg_pkg::LMEM_LOG_SIZE;
    localparam int unsigned IDX_LO   = mem_cfg_pkg::WORD_OFFSET_BITS;
    localparam int unsigned IDX_W    = LOG_SIZE - IDX_LO;

    logic [mem_cfg_pkg::DATA_WIDTH-1:0] mem [WORDS];

    logic [IDX_W-1:0] idx;
    logic             req_fire;
    logic             is_write;

    assign idx      = req.addr[LOG_SIZE-1:IDX_LO];
    assign is_write = req.op == mem_cfg_pkg::MEM_OP_WRITE;

    // Ready again in the cycle the held response leaves
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (req_fire && is_write) begin
            for (int b = 0; b < mem_cfg_pkg::BYTEEN_WIDTH; b++) begin
                if (req.byteen[b]) begin
                    mem[idx][b*8 +: 8] <= req.data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire && !is_write) begin
            rsp.data <= mem[idx];
            rsp.tag  <= req.tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (req_fire && !is_write) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // The switch only forwards addresses inside the window
    assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> (req.addr >> LOG_SIZE) == (mem_cfg_pkg::LMEM_BASE_ADDR >> LOG_SIZE));

    assert property (@(posedge clk) disable iff (!rst_n)
        WORDS == (1 << IDX_W));

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the memory unit testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --assert --top-module mem_unit_tb -f filelist.f -o mem_unit_sim

./obj_dir/mem_unit_sim | tee "$LOG"

if grep -q "RESULT: PASS" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// File: verilog/lmem_switch.sv
/*
 * Steers LSU requests to local memory or the global path by address window,
 * and merges both response streams onto one port with priority to local.
 */
module lmem_switch (
    input  logic                    clk,
    input  logic                    rst_n,

    // LSU request in
    input  logic                    in_req_valid,
    input  mem_types_pkg::mem_req_t in_req,
    output logic                    in_req_ready,

    // Local memory request out
    output logic                    local_req_valid,
    output mem_types_pkg::mem_req_t local_req,
    input  logic                    local_req_ready,

    // Global request out
    output logic                    global_req_valid,
    output mem_types_pkg::mem_req_t global_req,
    input  logic                    global_req_ready,

    // Responses from both paths
    input  logic                    local_rsp_valid,
    input  mem_types_pkg::mem_rsp_t local_rsp,
    output logic                    local_rsp_ready,
    input  logic                    global_rsp_valid,
    input  mem_types_pkg::mem_rsp_t global_rsp,
    output logic                    global_rsp_ready,

    // Merged response to the LSU
    output logic                    out_rsp_valid,
    output mem_types_pkg::mem_rsp_t out_rsp,
    input  logic                    out_rsp_ready
);
    localparam int unsigned LOG_SIZE = mem_cfg_pkg::LMEM_LOG_SIZE;

    logic is_local;
    logic sel_global;
    logic global_hold;

    // The window is aligned, so comparing the bits above its size is enough
    assign is_local = (in_req.addr >> LOG_SIZE) == (mem_cfg_pkg::LMEM_BASE_ADDR >> LOG_SIZE);

    assign local_req_valid  = in_req_valid & is_local;
    assign global_req_valid = in_req_valid & ~is_local;
    assign local_req        = in_req;
    assign global_req       = in_req;
    assign in_req_ready     = is_local ? local_req_ready : global_req_ready;

    // Local wins, unless a global response was already offered and stalled
    assign sel_global = global_hold | (global_rsp_valid & ~local_rsp_valid);

    assign out_rsp_valid    = local_rsp_valid | global_rsp_valid;
    assign out_rsp          = sel_global ? global_rsp : local_rsp;
    assign local_rsp_ready  = out_rsp_ready & ~sel_global;
    assign global_rsp_ready = out_rsp_ready & sel_global;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            global_hold <= 1'b0;
        end else begin
            global_hold <= sel_global & global_rsp_valid & ~out_rsp_ready;
        end
    end

    // Each response taken by the LSU leaves exactly one of the two paths
    assert property (@(posedge clk) disable iff (!rst_n)
        out_rsp_valid && out_rsp_ready |->
            (local_rsp_valid && local_rsp_ready) != (global_rsp_valid && global_rsp_ready));

    // The LSU must see a stalled response unchanged until it is taken
    assert property (@(posedge clk) disable iff (!rst_n)
        out_rsp_valid && !out_rsp_ready |=> out_rsp_valid && $stable(out_rsp));

endmodule

// File: verilog/mem_unit.sv
/*
 * Memory unit for one LSU port: local memory window plus a queued cache path.
 * Read responses of both paths return on the LSU response port.
 */
module mem_unit #(
    parameter int unsigned GQ_DEPTH   = 4,
    parameter int unsigned LMEM_WORDS = 256
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // LSU port
    input  logic                    lsu_req_valid,
    input  mem_types_pkg::mem_req_t lsu_req,
    output logic                    lsu_req_ready,
    output logic                    lsu_rsp_valid,
    output mem_types_pkg::mem_rsp_t lsu_rsp,
    input  logic                    lsu_rsp_ready,

    // Data cache port
    output logic                    dc_req_valid,
    output mem_types_pkg::mem_req_t dc_req,
    input  logic                    dc_req_ready,
    input  logic                    dc_rsp_valid,
    input  mem_types_pkg::mem_rsp_t dc_rsp,
    output logic                    dc_rsp_ready
);
    logic                    local_req_valid;
    mem_types_pkg::mem_req_t local_req;
    logic                    local_req_ready;
    logic                    local_rsp_valid;
    mem_types_pkg::mem_rsp_t local_rsp;
    logic                    local_rsp_ready;

    logic                    gq_in_valid;
    mem_types_pkg::mem_req_t gq_in;
    logic                    gq_in_ready;

    lmem_switch i_switch (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_req_valid     (lsu_req_valid),
        .in_req           (lsu_req),
        .in_req_ready     (lsu_req_ready),
        .local_req_valid  (local_req_valid),
        .local_req        (local_req),
        .local_req_ready  (local_req_ready),
        .global_req_valid (gq_in_valid),
        .global_req       (gq_in),
        .global_req_ready (gq_in_ready),
        .local_rsp_valid  (local_rsp_valid),
        .local_rsp        (local_rsp),
        .local_rsp_ready  (local_rsp_ready),
        .global_rsp_valid (dc_rsp_valid),
        .global_rsp       (dc_rsp),
        .global_rsp_ready (dc_rsp_ready),
        .out_rsp_valid    (lsu_rsp_valid),
        .out_rsp          (lsu_rsp),
        .out_rsp_ready    (lsu_rsp_ready)
    );

    req_fifo #(
        .DEPTH (GQ_DEPTH)
    ) i_gq (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (gq_in_valid),
        .in_data   (gq_in),
        .in_ready  (gq_in_ready),
        .out_valid (dc_req_valid),
        .out_data  (dc_req),
        .out_ready (dc_req_ready)
    );

    local_mem #(
        .WORDS (LMEM_WORDS)
    ) i_lmem (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (local_req_valid),
        .req       (local_req),
        .req_ready (local_req_ready),
        .rsp_valid (local_rsp_valid),
        .rsp       (local_rsp),
        .rsp_ready (local_rsp_ready)
    );

endmodule

// File: verilog/req_fifo.sv
/*
 * Circular request queue on the global path towards the cache port.
 * DEPTH must be a power of two; a push and a pop may share one cycle.
 */
module req_fifo #(
    parameter int unsigned DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    in_valid,
    input  mem_types_pkg::mem_req_t in_data,
    output logic                    in_ready,

    output logic                    out_valid,
    output mem_types_pkg::mem_req_t out_data,
    input  logic                    out_ready
);
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    mem_types_pkg::mem_req_t entries [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = count != CNT_W'(DEPTH);
    assign out_valid = count != '0;
    assign out_data  = entries[rd_ptr];

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Occupancy always matches the distance between the pointers
    assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(DEPTH) && count[PTR_W-1:0] == PTR_W'(wr_ptr - rd_ptr));

    // The head entry stays put while the cache port stalls
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule
